// ==== verilog.f ====
+incdir+verilog
verilog/eeprom_pkg.sv
verilog/i2c_line_sampler.sv
verilog/i2c_eeprom_ctrl.sv
verilog/eeprom_mem.sv
verilog/eeprom_top.sv
dv/eeprom_assertions.sv
dv/eeprom_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= eeprom_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^>>> PASS$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/eeprom_tb.sv ====
`timescale 1ns/1ns
`include "eeprom_cfg.svh"

module eeprom_tb;
    import eeprom_pkg::*;

    localparam int WAIT_LIMIT = 20000;

    logic sda;
    logic arst_n;
    logic scl;
    logic sda_m;
    logic ser_pull_low;
    wire  ser_in = sda_m & ~ser_pull_low;

    int       seed = 32'h62780419;
    int       mismatch_errs;
    int       proto_errs;
    int       timeout_errs;
    bit       stim_done;
    bit       cmp_done;
    ee_byte_t shadow [ee_addr_t];
    ee_addr_t rd_addr_q[$];
    ee_byte_t rd_data_q[$];

    eeprom_top u_dut (
        .sda          (sda),
        .arst_n       (arst_n),
        .scl          (scl),
        .ser_in       (ser_in),
        .ser_pull_low (ser_pull_low)
    );

    initial
    begin
        sda = 1'b0;
        forever #4 sda = ~sda;
    end

    initial
    begin
        arst_n = 1'b0;
        scl    = 1'b1;
        sda_m  = 1'b1;
        repeat (3) @(posedge sda);
        #1 arst_n = 1'b1;
    end

    initial
    begin
        repeat (400000) @(posedge sda);
        $display("simulation ran too long, stopped by the watchdog");
        $display(">>> FAIL");
        $finish;
    end

    function automatic ee_byte_t expected_byte(input ee_addr_t a);
        if (shadow.exists(a))
            return shadow[a];
        return 'x;
    endfunction

    task automatic tick(input int n);
        repeat (n) @(posedge sda);
        #1;
    endtask

    // one scl period with the wire sampled late in the high phase
    task automatic bus_bit(input logic b, output logic seen);
        scl = 1'b0;
        tick(4);
        sda_m = b;
        tick(4);
        scl = 1'b1;
        tick(7);
        seen = ser_in;
        tick(1);
    endtask

    task automatic start_cond();
        scl = 1'b0;
        tick(4);
        sda_m = 1'b1;
        tick(4);
        scl = 1'b1;
        tick(8);
        sda_m = 1'b0;
        tick(8);
    endtask

    task automatic stop_cond();
        scl = 1'b0;
        tick(4);
        sda_m = 1'b0;
        tick(4);
        scl = 1'b1;
        tick(8);
        sda_m = 1'b1;
        tick(8);
    endtask

    task automatic send_byte(input ee_byte_t v, output logic acked);
        logic s;
        for (int i = 7; i >= 0; i--)
            bus_bit(v[i], s);
        bus_bit(1'b1, s);
        acked = !s;
    endtask

    task automatic send_checked(input ee_byte_t v, input logic want_ack);
        logic acked;
        send_byte(v, acked);
        assert (acked == want_ack)
        else
        begin
            proto_errs++;
            $display("byte %h got the wrong acknowledge at %0t", v, $time);
        end
    endtask

    task automatic write_body(input ee_addr_t a, input ee_byte_t d);
        send_checked({`EE_DEV_CODE, a[10:8], 1'b0}, 1'b1);
        send_checked(a[7:0], 1'b1);
        send_checked(d, 1'b1);
    endtask

    task automatic write_byte(input ee_addr_t a, input ee_byte_t d);
        start_cond();
        write_body(a, d);
        stop_cond();
        shadow[a] = d;
    endtask

    task automatic read_byte(input ee_addr_t a);
        ee_byte_t v;
        logic     s;
        start_cond();
        send_checked({`EE_DEV_CODE, a[10:8], 1'b0}, 1'b1);
        send_checked(a[7:0], 1'b1);
        start_cond();
        send_checked({`EE_DEV_CODE, a[10:8], 1'b1}, 1'b1);
        for (int i = 7; i >= 0; i--)
        begin
            bus_bit(1'b1, s);
            v[i] = s;
        end
        // master not-acknowledge ends the read
        bus_bit(1'b1, s);
        stop_cond();
        rd_addr_q.push_back(a);
        rd_data_q.push_back(v);
    endtask

    // compares each read-back against the shadow memory
    initial
    begin
        ee_addr_t a;
        ee_byte_t v;
        int       n;
        forever
        begin
            n = 0;
            while (rd_data_q.size() == 0 && !stim_done && n < WAIT_LIMIT)
            begin
                @(posedge sda);
                n++;
            end
            if (rd_data_q.size() != 0)
            begin
                a = rd_addr_q.pop_front();
                v = rd_data_q.pop_front();
                assert (v === expected_byte(a))
                else
                begin
                    mismatch_errs++;
                    $display("Mismatch at %0t: addr %h expected %h got %h",
                             $time, a, expected_byte(a), v);
                end
            end
            else if (stim_done)
                break;
            else
            begin
                timeout_errs++;
                $display("no read result arrived within the wait limit");
            end
        end
        cmp_done = 1'b1;
    end

    initial
    begin
        ee_addr_t a;
        ee_byte_t d;
        logic     s;
        int       n;
        int       assert_errs;
        n = 0;
        while (arst_n !== 1'b1 && n < 100)
        begin
            @(posedge sda);
            n++;
        end
        if (arst_n !== 1'b1)
        begin
            timeout_errs++;
            $display("reset was never released");
        end
        tick(4);
        assert (!ser_pull_low)
        else
        begin
            proto_errs++;
            $display("data line pulled low right after reset");
        end
        write_byte(11'h123, 8'h5a);
        read_byte(11'h123);
        for (int i = 0; i < 20; i++)
        begin
            a = ee_addr_t'($random(seed));
            d = ee_byte_t'($random(seed));
            write_byte(a, d);
            read_byte(a);
        end
        // same address byte under every high address value
        for (int hi = 0; hi < 8; hi++)
            write_byte({hi[2:0], 8'h3c}, ee_byte_t'($random(seed)));
        for (int hi = 0; hi < 8; hi++)
            read_byte({hi[2:0], 8'h3c});
        // wrong device code is ignored
        start_cond();
        send_checked({4'b1011, 3'd1, 1'b0}, 1'b0);
        send_checked(8'h23, 1'b0);
        send_checked(8'hff, 1'b0);
        stop_cond();
        read_byte(11'h123);
        // stop inside the data byte
        start_cond();
        send_checked({`EE_DEV_CODE, 3'd1, 1'b0}, 1'b1);
        send_checked(8'h23, 1'b1);
        for (int i = 0; i < 3; i++)
            bus_bit(1'b0, s);
        stop_cond();
        read_byte(11'h123);
        // start inside the address byte
        start_cond();
        send_checked({`EE_DEV_CODE, 3'd2, 1'b0}, 1'b1);
        for (int i = 0; i < 4; i++)
            bus_bit(1'b1, s);
        start_cond();
        write_body(11'h2a7, 8'hc3);
        stop_cond();
        shadow[11'h2a7] = 8'hc3;
        read_byte(11'h2a7);
        // device stays quiet on the idle bus after a read
        for (int i = 0; i < 40; i++)
        begin
            tick(1);
            assert (!ser_pull_low)
            else
            begin
                proto_errs++;
                $display("data line pulled low on an idle bus at %0t", $time);
            end
        end
        write_byte(11'h7ff, 8'h81);
        read_byte(11'h7ff);
        stim_done = 1'b1;
        n = 0;
        while (!cmp_done && n < WAIT_LIMIT)
        begin
            @(posedge sda);
            n++;
        end
        if (!cmp_done)
        begin
            timeout_errs++;
            $display("comparison process did not finish");
        end
        assert_errs = u_dut.u_ctrl.u_assert.fail_cnt;
        $display("errors: mismatch=%0d protocol=%0d timeout=%0d assertion=%0d",
                 mismatch_errs, proto_errs, timeout_errs, assert_errs);
        if (mismatch_errs + proto_errs + timeout_errs + assert_errs == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== dv/eeprom_assertions.sv ====
`timescale 1ns/1ns

module eeprom_assertions (
    input logic                    sda,
    input logic                    arst_n,
    input eeprom_pkg::bus_evt_t    evt,
    input eeprom_pkg::ctrl_state_t state,
    input logic                    ser_pull_low,
    input logic                    mem_we,
    input logic                    mem_re
);
    import eeprom_pkg::*;

    int fail_cnt = 0;

    a_strobes_exclusive: assert property (@(posedge sda) disable iff (!arst_n)
        !(mem_we && mem_re))
    else
    begin
        fail_cnt++;
        $error("memory write and read strobes high together");
    end

    // the line only moves while scl is low
    a_pull_stable_on_rise: assert property (@(posedge sda) disable iff (!arst_n)
        (evt == scl_rise) |=> $stable(ser_pull_low))
    else
    begin
        fail_cnt++;
        $error("data line changed on an scl rise");
    end

    a_release_after_stop: assert property (@(posedge sda) disable iff (!arst_n)
        (evt == stop) |=> !ser_pull_low)
    else
    begin
        fail_cnt++;
        $error("data line still pulled after a stop");
    end

    a_idle_after_stop: assert property (@(posedge sda) disable iff (!arst_n)
        (evt == stop) |=> (state == idle))
    else
    begin
        fail_cnt++;
        $error("controller not idle after a stop");
    end

endmodule

bind i2c_eeprom_ctrl eeprom_assertions u_assert (
    .sda          (sda),
    .arst_n       (arst_n),
    .evt          (evt),
    .state        (state),
    .ser_pull_low (ser_pull_low),
    .mem_we       (mem_we),
    .mem_re       (mem_re)
);

// ==== verilog/eeprom_top.sv ====
`timescale 1ns/1ns

module eeprom_top (
    input  logic sda,
    input  logic arst_n,
    input  logic scl,
    input  logic ser_in,
    output logic ser_pull_low
);
    import eeprom_pkg::*;

    bus_evt_t evt;
    logic     bit_val;
    ee_addr_t mem_addr;
    ee_byte_t mem_wdata;
    ee_byte_t mem_rdata;
    logic     mem_we;
    logic     mem_re;

    i2c_line_sampler u_sampler (
        .sda     (sda),
        .arst_n  (arst_n),
        .scl     (scl),
        .ser_in  (ser_in),
        .evt     (evt),
        .bit_val (bit_val)
    );

    i2c_eeprom_ctrl u_ctrl (
        .sda          (sda),
        .arst_n       (arst_n),
        .evt          (evt),
        .bit_val      (bit_val),
        .mem_rdata    (mem_rdata),
        .ser_pull_low (ser_pull_low),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_we       (mem_we),
        .mem_re       (mem_re)
    );

    eeprom_mem u_mem (
        .sda       (sda),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .mem_re    (mem_re),
        .mem_rdata (mem_rdata)
    );

endmodule

// ==== verilog/eeprom_mem.sv ====
`timescale 1ns/1ns
`include "eeprom_cfg.svh"

module eeprom_mem (
    input  logic                 sda,
    input  eeprom_pkg::ee_addr_t mem_addr,
    input  eeprom_pkg::ee_byte_t mem_wdata,
    input  logic                 mem_we,
    input  logic                 mem_re,
    output eeprom_pkg::ee_byte_t mem_rdata
);
    import eeprom_pkg::*;

    localparam int DEPTH = 1 << `EE_ADDR_W;

    ee_byte_t storage [0:DEPTH-1];

    always_ff @(posedge sda)
    begin
        if (mem_we)
            storage[mem_addr] <= mem_wdata;
    end

    // read data holds until the next read strobe
    always_ff @(posedge sda)
    begin
        if (mem_re)
            mem_rdata <= storage[mem_addr];
    end

endmodule

// ==== verilog/i2c_eeprom_ctrl.sv ====
`timescale 1ns/1ns
`include "eeprom_cfg.svh"

module i2c_eeprom_ctrl (
    input  logic                 sda,
    input  logic                 arst_n,
    input  eeprom_pkg::bus_evt_t evt,
    input  logic                 bit_val,
    input  eeprom_pkg::ee_byte_t mem_rdata,
    output logic                 ser_pull_low,
    output eeprom_pkg::ee_addr_t mem_addr,
    output eeprom_pkg::ee_byte_t mem_wdata,
    output logic                 mem_we,
    output logic                 mem_re
);
    import eeprom_pkg::*;

    localparam int HI_W  = `EE_ADDR_W - `EE_DATA_W;
    localparam int CNT_W = $clog2(`EE_DATA_W + 1);

    ctrl_state_t     state;
    ctrl_state_t     ack_next;
    logic [CNT_W-1:0] bit_cnt;
    ee_byte_t        shift_reg;
    ee_byte_t        rx_byte;
    logic [HI_W-1:0] addr_hi;
    ee_byte_t        addr_lo;
    logic            receiving;
    logic            byte_done;

    // byte including the bit sampled this cycle
    assign rx_byte   = {shift_reg[`EE_DATA_W-2:0], bit_val};
    assign receiving = (state == get_ctrl) || (state == get_addr) || (state == get_data);
    assign byte_done = receiving && (evt == scl_rise)
                       && (bit_cnt == CNT_W'(`EE_DATA_W - 1));
    assign mem_addr  = {addr_hi, addr_lo};

    always_ff @(posedge sda or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state        <= idle;
            ack_next     <= idle;
            bit_cnt      <= '0;
            shift_reg    <= '0;
            addr_hi      <= '0;
            addr_lo      <= '0;
            mem_wdata    <= '0;
            mem_we       <= 1'b0;
            mem_re       <= 1'b0;
            ser_pull_low <= 1'b0;
        end
        else
        begin
            mem_we <= 1'b0;
            mem_re <= 1'b0;
            if (evt == start)
            begin
                state        <= get_ctrl;
                bit_cnt      <= '0;
                ser_pull_low <= 1'b0;
            end
            else if (evt == stop)
            begin
                state        <= idle;
                ser_pull_low <= 1'b0;
            end
            else
            begin
                if (receiving && evt == scl_rise)
                begin
                    shift_reg <= rx_byte;
                    bit_cnt   <= byte_done ? '0 : bit_cnt + 1'b1;
                end
                case (state)
                    get_ctrl:
                        if (byte_done)
                        begin
                            if (rx_byte[`EE_DATA_W-1 -: 4] == `EE_DEV_CODE)
                            begin
                                addr_hi  <= rx_byte[HI_W:1];
                                ack_next <= rx_byte[0] ? send_data : get_addr;
                                state    <= ack;
                            end
                            else
                                state <= idle;
                        end
                    get_addr:
                        if (byte_done)
                        begin
                            addr_lo  <= rx_byte;
                            ack_next <= get_data;
                            state    <= ack;
                        end
                    get_data:
                        if (byte_done)
                        begin
                            mem_wdata <= rx_byte;
                            mem_we    <= 1'b1;
                            ack_next  <= idle;
                            state     <= ack;
                        end
                    // first fall pulls the line, the second one ends the ack bit
                    ack:
                        if (evt == scl_rise && ack_next == send_data)
                            mem_re <= 1'b1;
                        else if (evt == scl_fall)
                        begin
                            if (!ser_pull_low)
                                ser_pull_low <= 1'b1;
                            else if (ack_next == send_data)
                            begin
                                ser_pull_low <= ~mem_rdata[`EE_DATA_W-1];
                                shift_reg    <= mem_rdata << 1;
                                bit_cnt      <= CNT_W'(1);
                                state        <= send_data;
                            end
                            else
                            begin
                                ser_pull_low <= 1'b0;
                                state        <= ack_next;
                            end
                        end
                    // msb first, one bit per low phase
                    send_data:
                        if (evt == scl_fall)
                        begin
                            if (bit_cnt == CNT_W'(`EE_DATA_W))
                            begin
                                ser_pull_low <= 1'b0;
                                state        <= wait_mack;
                            end
                            else
                            begin
                                ser_pull_low <= ~shift_reg[`EE_DATA_W-1];
                                shift_reg    <= shift_reg << 1;
                                bit_cnt      <= bit_cnt + 1'b1;
                            end
                        end
                    // single-byte reads, so a master ack also ends the transfer
                    wait_mack:
                        if (evt == scl_rise)
                            state <= idle;
                    default:
                        state <= idle;
                endcase
            end
        end
    end

endmodule

// ==== verilog/i2c_line_sampler.sv ====
`timescale 1ns/1ns
`include "eeprom_cfg.svh"

module i2c_line_sampler (
    input  logic                 sda,
    input  logic                 arst_n,
    input  logic                 scl,
    input  logic                 ser_in,
    output eeprom_pkg::bus_evt_t evt,
    output logic                 bit_val
);
    import eeprom_pkg::*;

    logic [`EE_SYNC_STAGES-1:0] scl_sync;
    logic [`EE_SYNC_STAGES-1:0] din_sync;
    logic                       scl_prev;
    logic                       din_prev;
    logic                       scl_now;
    logic                       din_now;
    bus_evt_t                   evt_next;

    assign scl_now = scl_sync[`EE_SYNC_STAGES-1];
    assign din_now = din_sync[`EE_SYNC_STAGES-1];

    // start and stop only happen with scl steady high
    always_comb
    begin
        evt_next = none;
        if (scl_now && scl_prev)
        begin
            if (din_prev && !din_now)
                evt_next = start;
            else if (!din_prev && din_now)
                evt_next = stop;
        end
        else if (scl_now)
            evt_next = scl_rise;
        else if (scl_prev)
            evt_next = scl_fall;
    end

    // idle bus is high on both lines
    always_ff @(posedge sda or negedge arst_n)
    begin
        if (!arst_n)
        begin
            scl_sync <= '1;
            din_sync <= '1;
            scl_prev <= 1'b1;
            din_prev <= 1'b1;
            evt      <= none;
            bit_val  <= 1'b1;
        end
        else
        begin
            scl_sync <= {scl_sync[`EE_SYNC_STAGES-2:0], scl};
            din_sync <= {din_sync[`EE_SYNC_STAGES-2:0], ser_in};
            scl_prev <= scl_now;
            din_prev <= din_now;
            evt      <= evt_next;
            bit_val  <= din_now;
        end
    end

endmodule

// ==== verilog/eeprom_pkg.sv ====
`include "eeprom_cfg.svh"

package eeprom_pkg;

    typedef logic [`EE_DATA_W-1:0] ee_byte_t;
    typedef logic [`EE_ADDR_W-1:0] ee_addr_t;

    // one bus occurrence per system clock
    typedef enum logic [2:0]
    {
        none,
        start,
        stop,
        scl_rise,
        scl_fall
    } bus_evt_t;

    typedef enum logic [2:0]
    {
        idle,
        get_ctrl,
        get_addr,
        get_data,
        ack,
        send_data,
        wait_mack
    } ctrl_state_t;

endpackage

// ==== verilog/eeprom_cfg.svh ====
`ifndef EEPROM_CFG_SVH
`define EEPROM_CFG_SVH

// 2 Kbyte array, byte wide
`define EE_ADDR_W 11
`define EE_DATA_W 8

// device type code in the top nibble of every control byte
`define EE_DEV_CODE 4'b1010

// flops per bus line ahead of the edge detector
`define EE_SYNC_STAGES 2

`endif
